//--- Makefile
# Verilator flow for the load/store unit

VERILATOR  ?= verilator
FLIST      ?= flist.f
RTL_TOP    ?= lsu_top
TB_TOP     ?= lsu_tb
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?=
PASS_TEXT  ?= Everything OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary --timing $(SIM_FLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR)

# pass only when the run prints the pass text
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- flist.f
hw/lsu_pkg.sv
hw/mem_req.sv
hw/dcache.sv
hw/backing_ram.sv
hw/mem_resp.sv
hw/lsu_top.sv
verif/lsu_tb.sv

//--- hw/backing_ram.sv
`timescale 1ns/1ns
`default_nettype none

module backing_ram import lsu_pkg::*; #(
    parameter int mem_words_log2 = 10,
    // cycles per access counting the request cycle, at least 2
    parameter int miss_latency   = 3
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     ram_req,
    input  logic     ram_we,
    input  logic [mem_words_log2-1:0] ram_addr,
    input  byte_en_t ram_be,
    input  word_t    ram_wdata,
    output logic     ram_ack,
    output word_t    ram_rdata
);

    localparam int cnt_w = $clog2(miss_latency + 1);

    word_t mem [1 << mem_words_log2];

    // access in progress
    logic [cnt_w-1:0] cnt;
    logic             q_we;
    logic [mem_words_log2-1:0] q_addr;
    byte_en_t         q_be;
    word_t            q_wdata;

    // zero fill after reset
    logic sweeping;
    logic [mem_words_log2-1:0] sweep_idx;

    logic start;

    assign start = (cnt == '0) && ram_req && !sweeping;

    // last cycle of the access carries ack and data
    assign ram_ack   = (cnt == cnt_w'(1));
    assign ram_rdata = mem[q_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else if (start) begin
            cnt <= cnt_w'(miss_latency - 1);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            q_we    <= ram_we;
            q_addr  <= ram_addr;
            q_be    <= ram_be;
            q_wdata <= ram_wdata;
        end
    end

    // one word per cycle until the top address
    always_ff @(posedge clk) begin
        if (reset) begin
            sweeping  <= 1'b1;
            sweep_idx <= '0;
        end else if (sweeping) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == '1) begin
                sweeping <= 1'b0;
            end
        end
    end

    // writes land at the end of the ack cycle
    always_ff @(posedge clk) begin
        if (sweeping) begin
            mem[sweep_idx] <= '0;
        end else if (ram_ack && q_we) begin
            for (int b = 0; b < 4; b++) begin
                if (q_be[b]) begin
                    mem[q_addr][8*b +: 8] <= q_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/dcache.sv
`timescale 1ns/1ns
`default_nettype none

module dcache import lsu_pkg::*; #(
    parameter int cache_lines_log2 = 4,
    parameter int mem_words_log2   = 10
) (
    input  logic     clk,
    input  logic     reset,
    // request from mem_req
    input  logic     valid,
    input  logic     op,
    input  addr_t    addr,
    input  byte_en_t write_type,
    input  word_t    w_data,
    // answer to mem_resp
    output logic     data_valid,
    output word_t    r_data,
    // backing memory side
    output logic     ram_req,
    output logic     ram_we,
    output logic [mem_words_log2-1:0] ram_addr,
    output byte_en_t ram_be,
    output word_t    ram_wdata,
    input  logic     ram_ack,
    input  word_t    ram_rdata
);

    // one word per line, tag is what is left of the word address
    localparam int idx_w = cache_lines_log2;
    localparam int tag_w = mem_words_log2 - cache_lines_log2;
    localparam int lines = 1 << cache_lines_log2;

    typedef enum logic [1:0] {
        idle,
        lookup,
        wait_ram,
        respond
    } state_t;

    state_t state;

    // latched request
    logic     req_op;
    addr_t    req_addr;
    byte_en_t req_be;
    word_t    req_wdata;

    // line storage
    logic [lines-1:0] line_valid;
    logic [tag_w-1:0] line_tag [lines];
    word_t            line_data [lines];

    // word fetched on a miss, or the old word on a store
    word_t resp_q;

    logic [idx_w-1:0] idx;
    logic [tag_w-1:0] tag;
    logic  hit;
    logic  load_hit;
    logic  accept;
    logic  ram_done;
    word_t merged;

    // index and tag come from the word address, upper bits wrap
    assign idx = req_addr[idx_w+1:2];
    assign tag = req_addr[mem_words_log2+1:idx_w+2];

    assign hit      = line_valid[idx] && (line_tag[idx] == tag);
    assign load_hit = (state == lookup) && !req_op && hit;
    assign ram_done = (state == wait_ram) && ram_ack;

    // hit answers straight from the array in the lookup cycle
    assign data_valid = load_hit || (state == respond);
    assign r_data     = (state == respond) ? resp_q : line_data[idx];

    // free again in the cycle that answers
    assign accept = valid && ((state == idle) || data_valid);

    // misses and every store go out to memory
    assign ram_req   = (state == lookup) && (req_op || !hit);
    assign ram_we    = req_op;
    assign ram_addr  = req_addr[mem_words_log2+1:2];
    assign ram_be    = req_be;
    assign ram_wdata = req_wdata;

    // store bytes laid over the cached word
    always_comb begin
        merged = line_data[idx];
        for (int b = 0; b < 4; b++) begin
            if (req_be[b]) begin
                merged[8*b +: 8] = req_wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else if (accept) begin
            state <= lookup;
        end else begin
            case (state)
                lookup:   state <= ram_req ? wait_ram : idle;
                wait_ram: state <= ram_ack ? respond : wait_ram;
                default:  state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op    <= op;
            req_addr  <= addr;
            req_be    <= write_type;
            req_wdata <= w_data;
        end
    end

    // only a load refill makes a line valid
    always_ff @(posedge clk) begin
        if (reset) begin
            line_valid <= '0;
        end else if (ram_done && !req_op) begin
            line_valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == lookup) && req_op && hit) begin
            // write-through, keep a hitting line current
            line_data[idx] <= merged;
        end else if (ram_done && !req_op) begin
            // refill, may evict an aliasing tag
            line_tag[idx]  <= tag;
            line_data[idx] <= ram_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_done) begin
            resp_q <= ram_rdata;
        end
    end

endmodule

`default_nettype wire

//--- hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // data word as seen by the pipeline and the memory
    typedef logic [31:0] word_t;

    // byte address, before any wrap to the memory size
    typedef logic [31:0] addr_t;

    // register file index for load results
    typedef logic [4:0] reg_idx_t;

    // exception code carried with the instruction
    // zero means nothing pending
    typedef logic [6:0] exc_t;

    // one enable per byte lane, lane 0 is bits 7:0
    typedef logic [3:0] byte_en_t;

    // access width, same encoding as mem_width in the pipeline
    typedef enum logic [1:0] {
        width_byte = 2'b00,
        width_half = 2'b01,
        width_word = 2'b10
    } width_t;

    // exception codes raised or passed by the memory stages
    localparam exc_t exc_none = 7'd0;
    // half or word load off its natural boundary
    localparam exc_t exc_load_misalign = 7'd4;
    // half or word store off its natural boundary
    localparam exc_t exc_store_misalign = 7'd6;

endpackage

`default_nettype wire

//--- hw/lsu_top.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_top import lsu_pkg::*; #(
    parameter int mem_words_log2   = 10,
    parameter int cache_lines_log2 = 4,
    parameter int miss_latency     = 3
) (
    input  logic     clk,
    input  logic     reset,
    // upstream, held while stall is high
    input  logic     mem_en_in,
    input  logic     mem_write,
    input  word_t    mem_sr,
    input  word_t    mem_imm,
    input  word_t    mem_data_in,
    input  width_t   mem_width_in,
    input  logic     mem_sign,
    input  reg_idx_t mem_rd_in,
    input  exc_t     mem_exp_in,
    // back to the pipeline
    output logic     stall,
    output logic     result_valid,
    output reg_idx_t result_rd,
    output word_t    result_data,
    output exc_t     result_exp
);

    // request to the cache
    logic     valid;
    logic     op;
    addr_t    addr;
    byte_en_t write_type;
    word_t    w_data;

    // tag path to mem_resp
    logic       req_en;
    reg_idx_t   req_rd;
    width_t     req_width;
    logic       req_sign;
    exc_t       req_exp;
    logic [1:0] req_byte_off;

    // cache answer
    logic  data_valid;
    word_t r_data;

    // cache to memory
    logic     ram_req;
    logic     ram_we;
    logic [mem_words_log2-1:0] ram_addr;
    byte_en_t ram_be;
    word_t    ram_wdata;
    logic     ram_ack;
    word_t    ram_rdata;

    mem_req u_req (
        .mem_en_in    (mem_en_in),
        .mem_write    (mem_write),
        .mem_sr       (mem_sr),
        .mem_imm      (mem_imm),
        .mem_data_in  (mem_data_in),
        .mem_width_in (mem_width_in),
        .mem_sign     (mem_sign),
        .mem_rd_in    (mem_rd_in),
        .mem_exp_in   (mem_exp_in),
        .valid        (valid),
        .op           (op),
        .addr         (addr),
        .write_type   (write_type),
        .w_data       (w_data),
        .req_en       (req_en),
        .req_rd       (req_rd),
        .req_width    (req_width),
        .req_sign     (req_sign),
        .req_exp      (req_exp),
        .req_byte_off (req_byte_off)
    );

    dcache #(
        .cache_lines_log2 (cache_lines_log2),
        .mem_words_log2   (mem_words_log2)
    ) u_cache (
        .clk        (clk),
        .reset      (reset),
        .valid      (valid),
        .op         (op),
        .addr       (addr),
        .write_type (write_type),
        .w_data     (w_data),
        .data_valid (data_valid),
        .r_data     (r_data),
        .ram_req    (ram_req),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_be     (ram_be),
        .ram_wdata  (ram_wdata),
        .ram_ack    (ram_ack),
        .ram_rdata  (ram_rdata)
    );

    backing_ram #(
        .mem_words_log2 (mem_words_log2),
        .miss_latency   (miss_latency)
    ) u_ram (
        .clk       (clk),
        .reset     (reset),
        .ram_req   (ram_req),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_be    (ram_be),
        .ram_wdata (ram_wdata),
        .ram_ack   (ram_ack),
        .ram_rdata (ram_rdata)
    );

    // issued means the request went to the cache
    mem_resp u_resp (
        .clk          (clk),
        .reset        (reset),
        .req_en       (req_en),
        .req_issued   (valid),
        .req_rd       (req_rd),
        .req_width    (req_width),
        .req_sign     (req_sign),
        .req_exp      (req_exp),
        .req_byte_off (req_byte_off),
        .data_valid   (data_valid),
        .r_data       (r_data),
        .stall        (stall),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data),
        .result_exp   (result_exp)
    );

endmodule

`default_nettype wire

//--- hw/mem_req.sv
`timescale 1ns/1ns
`default_nettype none

module mem_req import lsu_pkg::*; (
    // from the execute stage
    input  logic     mem_en_in,
    input  logic     mem_write,
    input  word_t    mem_sr,
    input  word_t    mem_imm,
    input  word_t    mem_data_in,
    input  width_t   mem_width_in,
    input  logic     mem_sign,
    input  reg_idx_t mem_rd_in,
    input  exc_t     mem_exp_in,
    // request to the data cache
    output logic     valid,
    output logic     op,
    output addr_t    addr,
    output byte_en_t write_type,
    output word_t    w_data,
    // tag fields for the response stage
    output logic     req_en,
    output reg_idx_t req_rd,
    output width_t   req_width,
    output logic     req_sign,
    output exc_t     req_exp,
    output logic [1:0] req_byte_off
);

    logic     misalign;
    byte_en_t be_base;

    // effective address, base plus offset
    assign addr = mem_sr + mem_imm;

    // half needs bit 0 clear, word needs both low bits clear
    always_comb begin
        case (mem_width_in)
            width_byte: misalign = 1'b0;
            width_half: misalign = addr[0];
            default:    misalign = addr[1:0] != 2'b00;
        endcase
    end

    // lane pattern before the shift, unknown widths act as word
    always_comb begin
        case (mem_width_in)
            width_byte: be_base = 4'b0001;
            width_half: be_base = 4'b0011;
            default:    be_base = 4'b1111;
        endcase
    end

    // move the pattern onto the addressed lanes
    assign write_type = be_base << addr[1:0];

    // store data copied into every lane, the enables pick the right one
    always_comb begin
        case (mem_width_in)
            width_byte: w_data = {4{mem_data_in[7:0]}};
            width_half: w_data = {2{mem_data_in[15:0]}};
            default:    w_data = mem_data_in;
        endcase
    end

    // only clean accesses reach the cache
    assign valid = mem_en_in && !misalign && (mem_exp_in == exc_none);
    assign op    = mem_write;

    assign req_en       = mem_en_in;
    assign req_width    = mem_width_in;
    assign req_sign     = mem_sign;
    assign req_byte_off = addr[1:0];

    // stores and empty slots never write a register
    assign req_rd = (mem_en_in && !mem_write) ? mem_rd_in : '0;

    // an older exception wins over our own misalignment
    always_comb begin
        if (mem_exp_in != exc_none) begin
            req_exp = mem_exp_in;
        end else if (misalign) begin
            req_exp = mem_write ? exc_store_misalign : exc_load_misalign;
        end else begin
            req_exp = exc_none;
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_resp.sv
`timescale 1ns/1ns
`default_nettype none

module mem_resp import lsu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    // tag fields from mem_req
    input  logic       req_en,
    input  logic       req_issued,
    input  reg_idx_t   req_rd,
    input  width_t     req_width,
    input  logic       req_sign,
    input  exc_t       req_exp,
    input  logic [1:0] req_byte_off,
    // from the data cache
    input  logic       data_valid,
    input  word_t      r_data,
    // to the pipeline
    output logic       stall,
    output logic       result_valid,
    output reg_idx_t   result_rd,
    output word_t      result_data,
    output exc_t       result_exp
);

    // waiting on the cache
    logic pending;
    // request that never went to the cache, finishes next cycle
    logic direct_q;

    // held tag of the request in flight
    reg_idx_t   rd_q;
    width_t     width_q;
    logic       sign_q;
    exc_t       exp_q;
    logic [1:0] off_q;

    logic  accept;
    logic  mem_done;
    word_t shifted;
    word_t load_val;

    // same rule the upstream uses to advance
    assign stall  = pending && !data_valid;
    assign accept = req_en && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending  <= 1'b0;
            direct_q <= 1'b0;
        end else begin
            direct_q <= accept && !req_issued;
            if (accept) begin
                pending <= req_issued;
            end else if (data_valid) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_q    <= req_rd;
            width_q <= req_width;
            sign_q  <= req_sign;
            exp_q   <= req_exp;
            off_q   <= req_byte_off;
        end
    end

    // addressed byte or half down to bit 0
    assign shifted = r_data >> {off_q, 3'b000};

    always_comb begin
        case (width_q)
            width_byte: load_val = {{24{sign_q & shifted[7]}}, shifted[7:0]};
            width_half: load_val = {{16{sign_q & shifted[15]}}, shifted[15:0]};
            default:    load_val = shifted;
        endcase
    end

    assign mem_done     = pending && data_valid;
    assign result_valid = mem_done || direct_q;
    assign result_rd    = result_valid ? rd_q : '0;
    assign result_exp   = result_valid ? exp_q : exc_none;

    // stores carry rd zero, so they return no data
    assign result_data = (mem_done && (rd_q != '0)) ? load_val : '0;

endmodule

`default_nettype wire

//--- verif/lsu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

    localparam int mem_words_log2   = 10;
    localparam int cache_lines_log2 = 4;
    localparam int miss_latency     = 3;
    localparam int mem_words        = 1 << mem_words_log2;
    // upper bound in cycles for any single wait
    localparam int wait_limit       = 4 * mem_words;

    logic     clk;
    logic     reset;
    logic     mem_en_in;
    logic     mem_write;
    word_t    mem_sr;
    word_t    mem_imm;
    word_t    mem_data_in;
    width_t   mem_width_in;
    logic     mem_sign;
    reg_idx_t mem_rd_in;
    exc_t     mem_exp_in;
    logic     stall;
    logic     result_valid;
    reg_idx_t result_rd;
    word_t    result_data;
    exc_t     result_exp;

    // memory contents as the pipeline should see them
    word_t model [mem_words];
    // expected results in issue order
    word_t    exp_data_q [$];
    exc_t     exp_exc_q [$];
    reg_idx_t exp_rd_q [$];
    logic [31:0] lcg_state;

    lsu_top #(
        .mem_words_log2   (mem_words_log2),
        .cache_lines_log2 (cache_lines_log2),
        .miss_latency     (miss_latency)
    ) u_dut (
        .clk          (clk),
        .reset        (reset),
        .mem_en_in    (mem_en_in),
        .mem_write    (mem_write),
        .mem_sr       (mem_sr),
        .mem_imm      (mem_imm),
        .mem_data_in  (mem_data_in),
        .mem_width_in (mem_width_in),
        .mem_sign     (mem_sign),
        .mem_rd_in    (mem_rd_in),
        .mem_exp_in   (mem_exp_in),
        .stall        (stall),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data),
        .result_exp   (result_exp)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] want);
        if (got !== want) begin
            fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, want));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // only the top lcg halves are used since low bits repeat quickly
    function automatic word_t rand_word();
        logic [15:0] hi;
        lcg_state = lcg_next(lcg_state);
        hi = lcg_state[31:16];
        lcg_state = lcg_next(lcg_state);
        return {hi, lcg_state[31:16]};
    endfunction

    // expected {exception, data} of one access from the model
    function automatic logic [38:0] ref_result(input logic write, input addr_t a,
            input width_t w, input logic sign, input exc_t exp_in);
        logic  mis;
        exc_t  exc;
        word_t val;
        mis = (w == width_half) ? a[0] : ((w == width_word) ? (a[1:0] != 2'b00) : 1'b0);
        if (exp_in != exc_none) begin
            exc = exp_in;
        end else if (mis) begin
            exc = write ? exc_store_misalign : exc_load_misalign;
        end else begin
            exc = exc_none;
        end
        // addressed bytes down to bit 0
        val = model[a[mem_words_log2+1:2]] >> (8 * a[1:0]);
        case (w)
            width_byte: val = sign ? {{24{val[7]}}, val[7:0]} : {24'd0, val[7:0]};
            width_half: val = sign ? {{16{val[15]}}, val[15:0]} : {16'd0, val[15:0]};
            default:    val = val;
        endcase
        if (write || exc != exc_none) begin
            val = '0;
        end
        return {exc, val};
    endfunction

    // low bytes of data land from the addressed lane upward
    task automatic model_store(input addr_t a, input width_t w, input word_t data);
        logic [mem_words_log2-1:0] idx;
        int nbytes;
        idx = a[mem_words_log2+1:2];
        nbytes = (w == width_byte) ? 1 : ((w == width_half) ? 2 : 4);
        for (int b = 0; b < nbytes; b++) begin
            model[idx][8*(a[1:0]+b) +: 8] = data[8*b +: 8];
        end
    endtask

    task automatic wait_sweep();
        int n;
        for (n = 0; n < wait_limit; n++) begin
            @(negedge clk);
            if (!u_dut.u_ram.sweeping) break;
        end
        if (n == wait_limit) fail_run("timeout waiting for the memory clear after reset");
    endtask

    // one access where want_lat zero accepts any latency
    task automatic access(input logic write, input word_t sr, input word_t imm,
            input word_t data, input width_t w, input logic sign, input reg_idx_t rd,
            input exc_t exp_in, input int want_lat);
        addr_t a;
        logic [38:0] want;
        int lat;
        int n;
        a = sr + imm;
        @(posedge clk);
        mem_en_in    <= 1'b1;
        mem_write    <= write;
        mem_sr       <= sr;
        mem_imm      <= imm;
        mem_data_in  <= data;
        mem_width_in <= w;
        mem_sign     <= sign;
        mem_rd_in    <= rd;
        mem_exp_in   <= exp_in;
        // held until a cycle with stall low
        for (n = 0; n < wait_limit; n++) begin
            @(negedge clk);
            if (!stall) break;
        end
        if (n == wait_limit) fail_run("timeout waiting for the request to be accepted");
        // taken at this edge
        @(posedge clk);
        mem_en_in <= 1'b0;
        want = ref_result(write, a, w, sign, exp_in);
        exp_data_q.push_back(want[31:0]);
        exp_exc_q.push_back(want[38:32]);
        exp_rd_q.push_back(write ? 5'd0 : rd);
        if (write && want[38:32] == exc_none) model_store(a, w, data);
        for (lat = 1; lat <= wait_limit; lat++) begin
            @(negedge clk);
            if (result_valid) break;
            // cache or ram still busy
            check_value("stall", 32'(stall), 32'd1);
        end
        if (lat > wait_limit) fail_run("timeout waiting for result_valid");
        check_value("stall", 32'(stall), 32'd0);
        if (want_lat != 0) check_value("latency", lat, want_lat);
    endtask

    // every result is checked mid-cycle against the queued expectation
    always @(negedge clk) begin
        if (!reset && result_valid) begin
            if (exp_data_q.size() == 0) begin
                fail_run("result_valid seen with no access outstanding");
            end else begin
                check_value("result_data", result_data, exp_data_q.pop_front());
                check_value("result_exp", 32'(result_exp), 32'(exp_exc_q.pop_front()));
                check_value("result_rd", 32'(result_rd), 32'(exp_rd_q.pop_front()));
            end
        end
    end

    initial begin
        width_t   w;
        word_t    r;
        word_t    sr;
        word_t    target;
        logic [1:0] off;
        reg_idx_t rd;
        clk = 1'b0;
        lcg_state = 32'h329a_ff53;
        for (int i = 0; i < mem_words; i++) model[i] = '0;
        reset        <= 1'b1;
        mem_en_in    <= 1'b0;
        mem_write    <= 1'b0;
        mem_sr       <= '0;
        mem_imm      <= '0;
        mem_data_in  <= '0;
        mem_width_in <= width_byte;
        mem_sign     <= 1'b0;
        mem_rd_in    <= '0;
        mem_exp_in   <= exc_none;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        wait_sweep();

        // word store and a load back through another base and offset
        access(1'b1, 32'h100, 32'h0, 32'hdead_beef, width_word, 1'b0, 5'd5, exc_none, 0);
        access(1'b0, 32'h0f0, 32'h10, 32'h0, width_word, 1'b0, 5'd7, exc_none, 0);

        // byte lanes on one word and half lanes on the next
        access(1'b1, 32'h40, 32'h0, 32'h1122_3344, width_word, 1'b0, 5'd1, exc_none, 0);
        access(1'b1, 32'h44, 32'h0, 32'h5566_7788, width_word, 1'b0, 5'd1, exc_none, 0);
        for (int o = 0; o < 4; o++) begin
            access(1'b1, 32'h40, o, 32'h81 + 32'h11 * o, width_byte, 1'b0, 5'd1, exc_none, 0);
        end
        access(1'b1, 32'h44, 32'h2, 32'h0000_8001, width_half, 1'b0, 5'd1, exc_none, 0);
        access(1'b1, 32'h44, 32'h0, 32'h0000_7ffe, width_half, 1'b0, 5'd1, exc_none, 0);
        for (int base = 32'h40; base <= 32'h44; base += 4) begin
            for (int wi = 0; wi < 3; wi++) begin
                w = (wi == 0) ? width_byte : ((wi == 1) ? width_half : width_word);
                for (int o = 0; o < 4; o += (1 << wi)) begin
                    access(1'b0, base, o, 32'h0, w, 1'b0, 5'd10, exc_none, 0);
                    access(1'b0, base, o, 32'h0, w, 1'b1, 5'd11, exc_none, 0);
                end
            end
        end

        // miss then hit timing
        // a store always pays the ram latency
        access(1'b0, 32'h300, 32'h0, 32'h0, width_word, 1'b0, 5'd3, exc_none, 1 + miss_latency);
        access(1'b0, 32'h300, 32'h0, 32'h0, width_word, 1'b0, 5'd3, exc_none, 1);
        access(1'b1, 32'h300, 32'h2, 32'h0000_abcd, width_half, 1'b0, 5'd0, exc_none,
               1 + miss_latency);
        // hitting line must carry the merged half
        access(1'b0, 32'h300, 32'h2, 32'h0, width_half, 1'b1, 5'd4, exc_none, 1);

        // misaligned and incoming exceptions finish next cycle
        // memory stays untouched
        access(1'b0, 32'h40, 32'h1, 32'h0, width_half, 1'b0, 5'd2, exc_none, 1);
        access(1'b1, 32'h40, 32'h2, 32'hffff_ffff, width_word, 1'b0, 5'd0, exc_none, 1);
        access(1'b1, 32'h40, 32'h0, 32'h0, width_word, 1'b0, 5'd0, 7'd13, 1);
        access(1'b0, 32'h40, 32'h0, 32'h0, width_word, 1'b0, 5'd9, 7'd2, 1);
        access(1'b0, 32'h40, 32'h0, 32'h0, width_word, 1'b0, 5'd9, exc_none, 0);

        // random mix over 4 tags on 4 indexes so lines alias often
        for (int i = 0; i < 400; i++) begin
            r = rand_word();
            w = (r[9:8] == 2'b11) ? width_word : width_t'(r[9:8]);
            off = r[7:6];
            // mostly aligned with a few misaligned on purpose
            if (r[22:20] != 3'b000) begin
                if (w == width_half) off[0] = 1'b0;
                if (w == width_word) off = 2'b00;
            end
            rd = (r[16:12] == 5'd0) ? 5'd1 : r[16:12];
            sr = rand_word();
            // upper bits beyond the memory wrap around
            target = {sr[31:12] ^ r[31:12], 4'b0000, r[3:2], 2'b00, r[5:4], off};
            access(r[10], sr, target - sr, rand_word(), w, r[11], rd,
                   (r[19:17] == 3'b000) ? 7'd2 : exc_none, 0);
        end

        repeat (2) @(posedge clk);
        if (exp_data_q.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            fail_run("results still missing at the end of the run");
        end
    end

endmodule

`default_nettype wire
